// ==== bench/core_cases.txt ====
# I <word>: program word, in order from the reset PC
# E <reg> <data>: expected register write, in program order (hex)
I 3c011234  # lui   $1, 0x1234
I 34215678  # ori   $1, $1, 0x5678
I 2402ffff  # addiu $2, $0, -1
I 24030005  # addiu $3, $0, 5
I 00232021  # addu  $4, $1, $3
I 00622823  # subu  $5, $3, $2
I 00223024  # and   $6, $1, $2
I 00853825  # or    $7, $4, $5
I 00e14026  # xor   $8, $7, $1
I 0043482a  # slt   $9, $2, $3
I 0062502a  # slt   $10, $3, $2
I 00015900  # sll   $11, $1, 4
I 00026702  # srl   $12, $2, 28
I 258d8000  # addiu $13, $12, 0x8000
I 340e8000  # ori   $14, $0, 0x8000
I 01ae7821  # addu  $15, $13, $14
I 00000000  # nop
I 01e98023  # subu  $16, $15, $9
I 10210003  # beq, unsupported
I 00210021  # addu  $0, $1, $1
I 020b0826  # xor   $1, $16, $11
I 00208821  # addu  $17, $1, $0
I 26310001  # addiu $17, $17, 1
I 24150011  # addiu $21, $0, 0x11
I 24150022  # addiu $21, $0, 0x22
I 02b5b021  # addu  $22, $21, $21
E 01 12340000
E 01 12345678
E 02 ffffffff
E 03 00000005
E 04 1234567d
E 05 00000006
E 06 12345678
E 07 1234567f
E 08 00000007
E 09 00000001
E 0a 00000000
E 0b 23456780
E 0c 0000000f
E 0d ffff800f
E 0e 00008000
E 0f 0000000f
E 10 0000000e
E 01 2345678e
E 11 2345678e
E 11 2345678f
E 15 00000011
E 15 00000022
E 16 00000044

// ==== verilog.f ====
design/cpu_cfg_pkg.sv
design/isa_pkg.sv
design/pc_fetch.sv
design/inst_fifo.sv
design/decoder.sv
design/issue_ctrl.sv
design/regfile_bypass.sv
design/exec_lane.sv
design/dual_issue_core.sv
bench/tb_dual_issue_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module tb_dual_issue_core \
    -Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -qF "*** FAILED ***" sim.log; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"

// ==== bench/tb_dual_issue_core.sv ====
`timescale 1ns/1ps

module tb_dual_issue_core import cpu_cfg_pkg::*; ();

    localparam int    FIFO_DEPTH = DEFAULT_FIFO_DEPTH;
    localparam word_t RESET_PC = DEFAULT_RESET_PC;

    logic      clk;
    logic      rst_i;
    logic      inst_data_ok_i;
    logic      inst_data_ok1_i;
    logic      inst_data_ok2_i;
    word_t     inst_rdata1_i;
    word_t     inst_rdata2_i;
    logic      inst_sram_en_o;
    word_t     inst_pc_o;
    logic      wb_master_wen_o;
    reg_addr_t wb_master_waddr_o;
    word_t     wb_master_wdata_o;
    logic      wb_slave_wen_o;
    reg_addr_t wb_slave_waddr_o;
    word_t     wb_slave_wdata_o;

    word_t     prog[$];
    reg_addr_t exp_addr[$];
    word_t     exp_data[$];
    int        n_exp = 0;
    int        exp_idx = 0;
    int        value_errs = 0;
    int        other_errs = 0;
    bit        cases_loaded = 1'b0;
    integer    seed = 32'he286e08f;
    word_t     fetch_pc = RESET_PC;

    dual_issue_core #(.FIFO_DEPTH(FIFO_DEPTH), .RESET_PC(RESET_PC)) i_dual_issue_core (
        .clk(clk), .rst_i(rst_i),
        .inst_data_ok_i(inst_data_ok_i), .inst_data_ok1_i(inst_data_ok1_i),
        .inst_data_ok2_i(inst_data_ok2_i),
        .inst_rdata1_i(inst_rdata1_i), .inst_rdata2_i(inst_rdata2_i),
        .inst_sram_en_o(inst_sram_en_o), .inst_pc_o(inst_pc_o),
        .wb_master_wen_o(wb_master_wen_o), .wb_master_waddr_o(wb_master_waddr_o),
        .wb_master_wdata_o(wb_master_wdata_o),
        .wb_slave_wen_o(wb_slave_wen_o), .wb_slave_waddr_o(wb_slave_waddr_o),
        .wb_slave_wdata_o(wb_slave_wdata_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errs++;
            $display("ERR %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("ERR %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_data(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("ERR %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    // nop past the end of the program
    function automatic word_t word_at(input int idx);
        word_t w;
        w = 32'h0;
        if (idx < prog.size()) begin
            w = prog[idx];
        end
        return w;
    endfunction

    task automatic load_cases(output bit ok);
        int          fd;
        int          c;
        int          n;
        word_t       w;
        logic [31:0] a;
        fd = $fopen("bench/core_cases.txt", "r");
        ok = 1'b0;
        if (fd == 0) begin
            $display("could not open bench/core_cases.txt");
        end else begin
            c = $fgetc(fd);
            while (c != -1) begin
                if (c == int'("#")) begin
                    while (c != -1 && c != int'("\n")) begin
                        c = $fgetc(fd);
                    end
                end else if (c == int'("I")) begin
                    n = $fscanf(fd, "%h", w);
                    if (n == 1) begin
                        prog.push_back(w);
                    end else begin
                        other_errs++;
                        $display("malformed program line in cases file");
                    end
                end else if (c == int'("E")) begin
                    n = $fscanf(fd, "%h %h", a, w);
                    if (n == 2) begin
                        exp_addr.push_back(reg_addr_t'(a));
                        exp_data.push_back(w);
                    end else begin
                        other_errs++;
                        $display("malformed expected-write line in cases file");
                    end
                end
                c = $fgetc(fd);
            end
            $fclose(fd);
            ok = (prog.size() > 0) && (exp_data.size() > 0);
        end
    endtask

    // master write counts first within a cycle
    task automatic record_write(input string lane, input reg_addr_t a, input word_t d);
        if (exp_idx >= n_exp) begin
            other_errs++;
            $display("%s wrote register %0d with 0x%h after the expected list ended",
                     lane, a, d);
        end else begin
            check_addr({lane, "_waddr_o"}, a, exp_addr[exp_idx]);
            check_data({lane, "_wdata_o"}, d, exp_data[exp_idx]);
            exp_idx++;
        end
    endtask

    task automatic finish_run();
        $display("value errors: %0d, other errors: %0d, writes seen: %0d of %0d",
                 value_errs, other_errs, exp_idx, n_exp);
        if (value_errs == 0 && other_errs == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    endtask

    // instruction responder
    initial begin : responder
        logic [31:0] r;
        int          idx;
        logic        pair;
        forever begin
            @(negedge clk);
            if (!rst_i && inst_sram_en_o) begin
                check_data("inst_pc_o", inst_pc_o, fetch_pc);
                idx = int'((fetch_pc - RESET_PC) >> 2);
                r = $random(seed);
                // last program word always comes alone
                pair = (r[3:2] != 2'b00) && (idx + 1 < prog.size());
                repeat (r[1:0]) @(posedge clk);
                @(posedge clk);
                inst_data_ok_i <= 1'b1;
                inst_data_ok1_i <= 1'b1;
                inst_data_ok2_i <= pair;
                inst_rdata1_i <= word_at(idx);
                inst_rdata2_i <= pair ? word_at(idx + 1) : 32'h0;
                @(posedge clk);
                inst_data_ok_i <= 1'b0;
                inst_data_ok1_i <= 1'b0;
                inst_data_ok2_i <= 1'b0;
                fetch_pc = fetch_pc + (pair ? 32'd8 : 32'd4);
            end
        end
    end

    always @(negedge clk) begin
        if (!rst_i) begin
            if (wb_master_wen_o) record_write("wb_master", wb_master_waddr_o, wb_master_wdata_o);
            if (wb_slave_wen_o) record_write("wb_slave", wb_slave_waddr_o, wb_slave_wdata_o);
        end
    end

    initial begin : watchdog
        int limit;
        wait (cases_loaded);
        limit = 40 * prog.size() + 200;
        repeat (limit) @(posedge clk);
        other_errs++;
        $display("timeout after %0d cycles, only %0d of %0d writes seen", limit, exp_idx, n_exp);
        finish_run();
    end

    initial begin : main
        bit loaded;
        rst_i = 1'b1;
        inst_data_ok_i = 1'b0;
        inst_data_ok1_i = 1'b0;
        inst_data_ok2_i = 1'b0;
        inst_rdata1_i = '0;
        inst_rdata2_i = '0;
        load_cases(loaded);
        if (!loaded) begin
            other_errs++;
        end else begin
            n_exp = exp_data.size();
            cases_loaded = 1'b1;
            repeat (5) @(posedge clk);
            rst_i <= 1'b0;
            @(negedge clk);
            check_flag("wb_master_wen_o", wb_master_wen_o, 1'b0);
            check_flag("wb_slave_wen_o", wb_slave_wen_o, 1'b0);
            check_flag("inst_sram_en_o", inst_sram_en_o, 1'b1);
            check_data("inst_pc_o", inst_pc_o, RESET_PC);
            while (exp_idx < n_exp) @(posedge clk);
            // catch stray writes behind the last one
            repeat (10) @(posedge clk);
        end
        finish_run();
    end

endmodule

// ==== design/dual_issue_core.sv ====
`timescale 1ns/1ps

module dual_issue_core import cpu_cfg_pkg::*, isa_pkg::*; #(
    parameter int    FIFO_DEPTH = DEFAULT_FIFO_DEPTH,
    parameter word_t RESET_PC = DEFAULT_RESET_PC
) (
    input  logic      clk,
    input  logic      rst_i,
    input  logic      inst_data_ok_i,
    input  logic      inst_data_ok1_i,
    input  logic      inst_data_ok2_i,
    input  word_t     inst_rdata1_i,
    input  word_t     inst_rdata2_i,
    output logic      inst_sram_en_o,
    output word_t     inst_pc_o,
    output logic      wb_master_wen_o,
    output reg_addr_t wb_master_waddr_o,
    output word_t     wb_master_wdata_o,
    output logic      wb_slave_wen_o,
    output reg_addr_t wb_slave_waddr_o,
    output word_t     wb_slave_wdata_o
);

    logic fifo_room, fifo_empty, fifo_one_left;
    logic wr1, wr2;
    word_t master_inst, slave_inst;
    logic master_issue, slave_issue;

    reg_addr_t master_rs, master_rt, master_waddr;
    reg_addr_t slave_rs, slave_rt, slave_waddr;
    logic master_reg_wen, slave_reg_wen;
    alu_op_e master_alu_op, slave_alu_op;
    logic master_use_shamt, slave_use_shamt, master_use_imm, slave_use_imm;
    word_t master_imm, slave_imm;
    logic [4:0] master_shamt, slave_shamt;
    word_t master_rs_val, master_rt_val, slave_rs_val, slave_rt_val;

    logic e_master_wen, e_slave_wen, m_master_wen, m_slave_wen;
    reg_addr_t e_master_waddr, e_slave_waddr, m_master_waddr, m_slave_waddr;
    word_t e_master_wdata, e_slave_wdata, m_master_wdata, m_slave_wdata;

    assign wr1 = inst_data_ok_i && inst_data_ok1_i;
    assign wr2 = inst_data_ok_i && inst_data_ok1_i && inst_data_ok2_i;

    pc_fetch #(.RESET_PC(RESET_PC)) u_pc_fetch (
        .clk(clk), .rst_i(rst_i),
        .inst_data_ok_i(inst_data_ok_i), .inst_data_ok2_i(inst_data_ok2_i),
        .fifo_room_i(fifo_room),
        .inst_sram_en_o(inst_sram_en_o), .inst_pc_o(inst_pc_o)
    );

    // PCs stay in the queue for debug, nothing downstream reads them
    inst_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_inst_fifo (
        .clk(clk), .rst_i(rst_i),
        .wr1_i(wr1), .wr2_i(wr2), .wr_pc_i(inst_pc_o),
        .wr_inst1_i(inst_rdata1_i), .wr_inst2_i(inst_rdata2_i),
        .pop1_i(master_issue), .pop2_i(slave_issue),
        .head_inst_o(master_inst), .head_pc_o(),
        .next_inst_o(slave_inst), .next_pc_o(),
        .empty_o(fifo_empty), .one_left_o(fifo_one_left), .room_o(fifo_room)
    );

    decoder u_decoder_master (
        .inst_i(master_inst), .rs_o(master_rs), .rt_o(master_rt),
        .waddr_o(master_waddr), .reg_wen_o(master_reg_wen), .alu_op_o(master_alu_op),
        .use_shamt_o(master_use_shamt), .use_imm_o(master_use_imm),
        .imm_o(master_imm), .shamt_o(master_shamt)
    );

    decoder u_decoder_slave (
        .inst_i(slave_inst), .rs_o(slave_rs), .rt_o(slave_rt),
        .waddr_o(slave_waddr), .reg_wen_o(slave_reg_wen), .alu_op_o(slave_alu_op),
        .use_shamt_o(slave_use_shamt), .use_imm_o(slave_use_imm),
        .imm_o(slave_imm), .shamt_o(slave_shamt)
    );

    issue_ctrl u_issue_ctrl (
        .empty_i(fifo_empty), .one_left_i(fifo_one_left),
        .master_waddr_i(master_waddr), .master_reg_wen_i(master_reg_wen),
        .slave_rs_i(slave_rs), .slave_rt_i(slave_rt),
        .master_issue_o(master_issue), .slave_issue_o(slave_issue)
    );

    regfile_bypass u_regfile_bypass (
        .clk(clk), .rst_i(rst_i),
        .ra1_i(master_rs), .ra2_i(master_rt), .ra3_i(slave_rs), .ra4_i(slave_rt),
        .rd1_o(master_rs_val), .rd2_o(master_rt_val),
        .rd3_o(slave_rs_val), .rd4_o(slave_rt_val),
        .e_master_wen_i(e_master_wen), .e_master_waddr_i(e_master_waddr),
        .e_master_wdata_i(e_master_wdata),
        .e_slave_wen_i(e_slave_wen), .e_slave_waddr_i(e_slave_waddr),
        .e_slave_wdata_i(e_slave_wdata),
        .m_master_wen_i(m_master_wen), .m_master_waddr_i(m_master_waddr),
        .m_master_wdata_i(m_master_wdata),
        .m_slave_wen_i(m_slave_wen), .m_slave_waddr_i(m_slave_waddr),
        .m_slave_wdata_i(m_slave_wdata),
        .w_master_wen_i(wb_master_wen_o), .w_master_waddr_i(wb_master_waddr_o),
        .w_master_wdata_i(wb_master_wdata_o),
        .w_slave_wen_i(wb_slave_wen_o), .w_slave_waddr_i(wb_slave_waddr_o),
        .w_slave_wdata_i(wb_slave_wdata_o)
    );

    exec_lane u_lane_master (
        .clk(clk), .rst_i(rst_i), .issue_i(master_issue),
        .reg_wen_i(master_reg_wen), .waddr_i(master_waddr), .alu_op_i(master_alu_op),
        .use_shamt_i(master_use_shamt), .use_imm_i(master_use_imm),
        .imm_i(master_imm), .shamt_i(master_shamt),
        .rs_val_i(master_rs_val), .rt_val_i(master_rt_val),
        .e_wen_o(e_master_wen), .e_waddr_o(e_master_waddr), .e_wdata_o(e_master_wdata),
        .m_wen_o(m_master_wen), .m_waddr_o(m_master_waddr), .m_wdata_o(m_master_wdata),
        .w_wen_o(wb_master_wen_o), .w_waddr_o(wb_master_waddr_o),
        .w_wdata_o(wb_master_wdata_o)
    );

    exec_lane u_lane_slave (
        .clk(clk), .rst_i(rst_i), .issue_i(slave_issue),
        .reg_wen_i(slave_reg_wen), .waddr_i(slave_waddr), .alu_op_i(slave_alu_op),
        .use_shamt_i(slave_use_shamt), .use_imm_i(slave_use_imm),
        .imm_i(slave_imm), .shamt_i(slave_shamt),
        .rs_val_i(slave_rs_val), .rt_val_i(slave_rt_val),
        .e_wen_o(e_slave_wen), .e_waddr_o(e_slave_waddr), .e_wdata_o(e_slave_wdata),
        .m_wen_o(m_slave_wen), .m_waddr_o(m_slave_waddr), .m_wdata_o(m_slave_wdata),
        .w_wen_o(wb_slave_wen_o), .w_waddr_o(wb_slave_waddr_o),
        .w_wdata_o(wb_slave_wdata_o)
    );

endmodule

// ==== design/exec_lane.sv ====
`timescale 1ns/1ps

module exec_lane import cpu_cfg_pkg::*, isa_pkg::*; (
    input  logic       clk,
    input  logic       rst_i,
    input  logic       issue_i,
    input  logic       reg_wen_i,
    input  reg_addr_t  waddr_i,
    input  alu_op_e    alu_op_i,
    input  logic       use_shamt_i,
    input  logic       use_imm_i,
    input  word_t      imm_i,
    input  logic [4:0] shamt_i,
    input  word_t      rs_val_i,
    input  word_t      rt_val_i,
    output logic       e_wen_o,
    output reg_addr_t  e_waddr_o,
    output word_t      e_wdata_o,
    output logic       m_wen_o,
    output reg_addr_t  m_waddr_o,
    output word_t      m_wdata_o,
    output logic       w_wen_o,
    output reg_addr_t  w_waddr_o,
    output word_t      w_wdata_o
);

    word_t   e_a, e_b;
    alu_op_e e_op;

    // operands picked in D, registered into E
    always_ff @(posedge clk) begin
        e_a <= use_shamt_i ? word_t'(shamt_i) : rs_val_i;
        e_b <= use_imm_i ? imm_i : rt_val_i;
        e_op <= alu_op_i;
        e_waddr_o <= waddr_i;
        m_waddr_o <= e_waddr_o;
        m_wdata_o <= e_wdata_o;
        w_waddr_o <= m_waddr_o;
        w_wdata_o <= m_wdata_o;
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            e_wen_o <= 1'b0;
            m_wen_o <= 1'b0;
            w_wen_o <= 1'b0;
        end else begin
            // bubble when not issued
            e_wen_o <= issue_i && reg_wen_i;
            m_wen_o <= e_wen_o;
            w_wen_o <= m_wen_o;
        end
    end

    always_comb begin
        case (e_op)
            ALU_ADD: e_wdata_o = e_a + e_b;
            ALU_SUB: e_wdata_o = e_a - e_b;
            ALU_AND: e_wdata_o = e_a & e_b;
            ALU_OR:  e_wdata_o = e_a | e_b;
            ALU_XOR: e_wdata_o = e_a ^ e_b;
            ALU_SLT: e_wdata_o = word_t'($signed(e_a) < $signed(e_b));
            // shift amount sits in a, value in b
            ALU_SLL: e_wdata_o = e_b << e_a[4:0];
            ALU_SRL: e_wdata_o = e_b >> e_a[4:0];
            ALU_LUI: e_wdata_o = e_b;
            default: e_wdata_o = '0;
        endcase
    end

endmodule

// ==== design/regfile_bypass.sv ====
`timescale 1ns/1ps

module regfile_bypass import cpu_cfg_pkg::*; (
    input  logic      clk,
    input  logic      rst_i,
    input  reg_addr_t ra1_i,
    input  reg_addr_t ra2_i,
    input  reg_addr_t ra3_i,
    input  reg_addr_t ra4_i,
    output word_t     rd1_o,
    output word_t     rd2_o,
    output word_t     rd3_o,
    output word_t     rd4_o,
    input  logic      e_master_wen_i,
    input  reg_addr_t e_master_waddr_i,
    input  word_t     e_master_wdata_i,
    input  logic      e_slave_wen_i,
    input  reg_addr_t e_slave_waddr_i,
    input  word_t     e_slave_wdata_i,
    input  logic      m_master_wen_i,
    input  reg_addr_t m_master_waddr_i,
    input  word_t     m_master_wdata_i,
    input  logic      m_slave_wen_i,
    input  reg_addr_t m_slave_waddr_i,
    input  word_t     m_slave_wdata_i,
    input  logic      w_master_wen_i,
    input  reg_addr_t w_master_waddr_i,
    input  word_t     w_master_wdata_i,
    input  logic      w_slave_wen_i,
    input  reg_addr_t w_slave_waddr_i,
    input  word_t     w_slave_wdata_i
);

    word_t regs [NUM_REGS];

    // younger stage first, slave before master within a stage
    function automatic word_t resolve(input reg_addr_t addr);
        word_t val;
        if (addr == '0) val = '0;
        else if (e_slave_wen_i && e_slave_waddr_i == addr) val = e_slave_wdata_i;
        else if (e_master_wen_i && e_master_waddr_i == addr) val = e_master_wdata_i;
        else if (m_slave_wen_i && m_slave_waddr_i == addr) val = m_slave_wdata_i;
        else if (m_master_wen_i && m_master_waddr_i == addr) val = m_master_wdata_i;
        else if (w_slave_wen_i && w_slave_waddr_i == addr) val = w_slave_wdata_i;
        else if (w_master_wen_i && w_master_waddr_i == addr) val = w_master_wdata_i;
        else val = regs[addr];
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (w_master_wen_i) begin
                regs[w_master_waddr_i] <= w_master_wdata_i;
            end
            // slave is younger, so it wins a same-address write
            if (w_slave_wen_i) begin
                regs[w_slave_waddr_i] <= w_slave_wdata_i;
            end
        end
    end

    always_comb begin
        rd1_o = resolve(ra1_i);
        rd2_o = resolve(ra2_i);
        rd3_o = resolve(ra3_i);
        rd4_o = resolve(ra4_i);
    end

endmodule

// ==== design/issue_ctrl.sv ====
`timescale 1ns/1ps

module issue_ctrl import cpu_cfg_pkg::*, isa_pkg::*; (
    input  logic      empty_i,
    input  logic      one_left_i,
    input  reg_addr_t master_waddr_i,
    input  logic      master_reg_wen_i,
    input  reg_addr_t slave_rs_i,
    input  reg_addr_t slave_rt_i,
    output logic      master_issue_o,
    output logic      slave_issue_o
);

    logic raw_hazard;

    // slave reads what the master of the same pair writes
    assign raw_hazard = master_reg_wen_i && (master_waddr_i != REG_ZERO) &&
                        ((slave_rs_i == master_waddr_i) || (slave_rt_i == master_waddr_i));

    assign master_issue_o = !empty_i;
    assign slave_issue_o = !empty_i && !one_left_i && !raw_hazard;

endmodule

// ==== design/decoder.sv ====
`timescale 1ns/1ps

module decoder import cpu_cfg_pkg::*, isa_pkg::*; (
    input  word_t       inst_i,
    output reg_addr_t   rs_o,
    output reg_addr_t   rt_o,
    output reg_addr_t   waddr_o,
    output logic        reg_wen_o,
    output alu_op_e     alu_op_o,
    output logic        use_shamt_o,
    output logic        use_imm_o,
    output word_t       imm_o,
    output logic [4:0]  shamt_o
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = inst_i[31:26];
    assign funct = inst_i[5:0];
    assign rs_o = inst_i[25:21];
    assign rt_o = inst_i[20:16];
    assign shamt_o = inst_i[10:6];

    always_comb begin
        alu_op_o = ALU_NOP;
        waddr_o = inst_i[15:11];
        use_shamt_o = 1'b0;
        use_imm_o = 1'b0;
        imm_o = {{16{inst_i[15]}}, inst_i[15:0]};
        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    FN_ADDU: alu_op_o = ALU_ADD;
                    FN_SUBU: alu_op_o = ALU_SUB;
                    FN_AND:  alu_op_o = ALU_AND;
                    FN_OR:   alu_op_o = ALU_OR;
                    FN_XOR:  alu_op_o = ALU_XOR;
                    FN_SLT:  alu_op_o = ALU_SLT;
                    FN_SLL:  alu_op_o = ALU_SLL;
                    FN_SRL:  alu_op_o = ALU_SRL;
                    default: alu_op_o = ALU_NOP;
                endcase
                use_shamt_o = (funct == FN_SLL) || (funct == FN_SRL);
            end
            OP_ADDIU: begin
                alu_op_o = ALU_ADD;
                use_imm_o = 1'b1;
                waddr_o = inst_i[20:16];
            end
            OP_ORI: begin
                alu_op_o = ALU_OR;
                use_imm_o = 1'b1;
                waddr_o = inst_i[20:16];
                imm_o = {16'b0, inst_i[15:0]};
            end
            OP_LUI: begin
                alu_op_o = ALU_LUI;
                use_imm_o = 1'b1;
                waddr_o = inst_i[20:16];
                imm_o = {inst_i[15:0], 16'b0};
            end
            default: alu_op_o = ALU_NOP;
        endcase
        // sll $0,$0,0 is the canonical nop and drops out here
        reg_wen_o = (alu_op_o != ALU_NOP) && (waddr_o != REG_ZERO);
    end

endmodule

// ==== design/inst_fifo.sv ====
`timescale 1ns/1ps

module inst_fifo import cpu_cfg_pkg::*; #(
    parameter int FIFO_DEPTH = DEFAULT_FIFO_DEPTH
) (
    input  logic  clk,
    input  logic  rst_i,
    input  logic  wr1_i,
    input  logic  wr2_i,
    input  word_t wr_pc_i,
    input  word_t wr_inst1_i,
    input  word_t wr_inst2_i,
    input  logic  pop1_i,
    input  logic  pop2_i,
    output word_t head_inst_o,
    output word_t head_pc_o,
    output word_t next_inst_o,
    output word_t next_pc_o,
    output logic  empty_o,
    output logic  one_left_o,
    output logic  room_o
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    word_t inst_mem [FIFO_DEPTH];
    word_t pc_mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [PTR_W-1:0] wr_ptr_p1, rd_ptr_p1;
    logic [PTR_W:0] count;
    logic [PTR_W:0] n_wr, n_rd;

    assign wr_ptr_p1 = wr_ptr + 1'b1;
    assign rd_ptr_p1 = rd_ptr + 1'b1;
    assign n_wr = (PTR_W+1)'(wr1_i) + (PTR_W+1)'(wr2_i);
    assign n_rd = (PTR_W+1)'(pop1_i) + (PTR_W+1)'(pop2_i);

    always_ff @(posedge clk) begin
        if (wr1_i) begin
            inst_mem[wr_ptr] <= wr_inst1_i;
            pc_mem[wr_ptr] <= wr_pc_i;
        end
        // second word lands behind the first
        if (wr2_i) begin
            inst_mem[wr_ptr_p1] <= wr_inst2_i;
            pc_mem[wr_ptr_p1] <= wr_pc_i + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            wr_ptr <= wr_ptr + n_wr[PTR_W-1:0];
            rd_ptr <= rd_ptr + n_rd[PTR_W-1:0];
            count <= count + n_wr - n_rd;
        end
    end

    assign head_inst_o = inst_mem[rd_ptr];
    assign head_pc_o = pc_mem[rd_ptr];
    assign next_inst_o = inst_mem[rd_ptr_p1];
    assign next_pc_o = pc_mem[rd_ptr_p1];

    assign empty_o = (count == '0);
    assign one_left_o = (count == (PTR_W+1)'(1));
    assign room_o = (count <= (PTR_W+1)'(FIFO_DEPTH - 2));

endmodule

// ==== design/pc_fetch.sv ====
`timescale 1ns/1ps

module pc_fetch import cpu_cfg_pkg::*; #(
    parameter word_t RESET_PC = DEFAULT_RESET_PC
) (
    input  logic  clk,
    input  logic  rst_i,
    input  logic  inst_data_ok_i,
    input  logic  inst_data_ok2_i,
    input  logic  fifo_room_i,
    output logic  inst_sram_en_o,
    output word_t inst_pc_o
);

    word_t pc_q;

    // request only while a whole pair fits in the queue
    assign inst_sram_en_o = fifo_room_i;
    assign inst_pc_o = pc_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q <= RESET_PC;
        end else if (inst_data_ok_i) begin
            // skip one word or two
            pc_q <= inst_data_ok2_i ? pc_q + 32'd8 : pc_q + 32'd4;
        end
    end

endmodule

// ==== design/isa_pkg.sv ====
package isa_pkg;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_ADDIU = 6'b001001;
    localparam logic [5:0] OP_ORI = 6'b001101;
    localparam logic [5:0] OP_LUI = 6'b001111;

    // SPECIAL funct field
    localparam logic [5:0] FN_SLL = 6'b000000;
    localparam logic [5:0] FN_SRL = 6'b000010;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND = 6'b100100;
    localparam logic [5:0] FN_OR = 6'b100101;
    localparam logic [5:0] FN_XOR = 6'b100110;
    localparam logic [5:0] FN_SLT = 6'b101010;

    // $zero, never written
    localparam logic [4:0] REG_ZERO = 5'd0;

    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI
    } alu_op_e;

endpackage

// ==== design/cpu_cfg_pkg.sv ====
package cpu_cfg_pkg;

    localparam int XLEN = 32;
    localparam int REG_AW = 5;
    localparam int NUM_REGS = 1 << REG_AW;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [REG_AW-1:0] reg_addr_t;

    // instruction queue depth, in instructions
    localparam int DEFAULT_FIFO_DEPTH = 16;

    // boot vector
    localparam word_t DEFAULT_RESET_PC = 32'hbfc00000;

endpackage
